//--- verif/uart_mailbox_tests.txt
# op name arg0 arg1 expect, numbers in hex. div and ctrl take the word in arg0 and expect
# the command word after the acknowledge; tx and burst (count, first byte) expect bytes.
# rx sends arg0 with parity flipped if arg1 is 1; flush drops arg0 and keeps arg1.
tx tx_reset_div a5 0 a5
div div_ten a 0 0
tx tx_plain 3c 0 3c
burst tx_burst 6 40 40
rx rx_plain 81 0 81
ctrl ctrl_even 1 0 0
tx tx_even 7e 0 7e
rx rx_even 55 0 55
rx rx_even_bad 55 1 155
ctrl ctrl_odd 3 0 0
div div_twelve c 0 0
tx tx_odd 01 0 01
burst tx_burst_odd 5 f0 f0
rx rx_odd c3 0 c3
rx rx_odd_bad 0f 1 10f
flush rx_flush 11 22 22
ctrl ctrl_off 0 0 0
rx rx_off_flip 99 1 99

//--- all.f
+incdir+include
design/uart_reg_pkg.sv
design/uart_stream_pkg.sv
design/stream_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_bram_ctrl.sv
design/uart_mailbox_top.sv
verif/tb_uart_mailbox.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the UART mailbox testbench with Verilator and runs it from the project root.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_uart_mailbox -f all.f -o sim_uart_mailbox
./obj_dir/sim_uart_mailbox | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

//--- verif/tb_uart_mailbox.sv
// Testbench for the RAM-mailbox UART.
// Models the shared RAM and the far end of the serial line, runs the tests listed in
// the test data file and prints one line per test and a closing summary.

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module tb_uart_mailbox;

import uart_reg_pkg::*;
import uart_stream_pkg::*;

localparam int CLK_PERIOD = 40;
localparam int MAX_TESTS  = 64;
localparam int MEM_WORDS  = 8;
localparam int MEM_AW     = $clog2(MEM_WORDS);

logic                        clk_i;
logic                        arstn_i;
logic                        uart_rx_i;
logic                        uart_tx_o;
logic [`UART_MEM_WIDTH-1:0]  mem_rdata_i;
logic [`UART_MEM_WIDTH-1:0]  mem_wdata_o;
logic [`UART_ADDR_WIDTH-1:0] mem_addr_o;
logic [`UART_BYTE_NUM-1:0]   mem_wr_en_o;

logic [`UART_MEM_WIDTH-1:0] mem [MEM_WORDS];

logic [127:0] test_op   [MAX_TESTS];
string        test_name [MAX_TESTS];
logic [31:0]  test_arg0 [MAX_TESTS];
logic [31:0]  test_arg1 [MAX_TESTS];
logic [31:0]  test_exp  [MAX_TESTS];
int           num_tests;
longint       budget_ns;
bit           budget_ready;

// Line settings the far end uses, updated once a command is acknowledged.
uart_div_t  cur_div;
uart_ctrl_t cur_ctrl;
uart_byte_t tx_frames [$];
bit         tx_frame_ok [$];
int         errors;

initial clk_i = 1'b0;
always #(CLK_PERIOD / 2) clk_i = ~clk_i;

uart_mailbox_top uart_mailbox_top_inst (
    .clk_i       (clk_i      ),
    .arstn_i     (arstn_i    ),
    .uart_rx_i   (uart_rx_i  ),
    .uart_tx_o   (uart_tx_o  ),
    .mem_rdata_i (mem_rdata_i),
    .mem_wdata_o (mem_wdata_o),
    .mem_addr_o  (mem_addr_o ),
    .mem_wr_en_o (mem_wr_en_o)
);

// RAM model. Writes land on the rising edge, the read data follows on the falling edge.
always @(posedge clk_i) begin
    if (mem_wr_en_o == '1) begin
        mem[mem_addr_o[MEM_AW-1:0]] <= mem_wdata_o;
    end
end

always @(negedge clk_i) begin
    mem_rdata_i <= mem[mem_addr_o[MEM_AW-1:0]];
end

// Far end receiver, decodes every frame on the DUT's serial output.
initial begin : line_monitor
    uart_byte_t data;
    logic       par;
    bit         ok;
    forever begin
        @(negedge clk_i);
        if (arstn_i && !uart_tx_o) begin
            repeat (cur_div / 2) @(negedge clk_i);
            for (int i = 0; i < `UART_DATA_WIDTH; i++) begin
                repeat (cur_div) @(negedge clk_i);
                data[i] = uart_tx_o;
            end
            par = ^data ^ cur_ctrl.parity_odd;
            ok  = 1'b1;
            if (cur_ctrl.parity_en) begin
                repeat (cur_div) @(negedge clk_i);
                ok = (uart_tx_o == par);
            end
            repeat (cur_div) @(negedge clk_i);
            if (!uart_tx_o) begin
                $display("Frame 0x%02h on uart_tx_o ended with a low stop bit", data);
                errors++;
            end
            tx_frames.push_back(data);
            tx_frame_ok.push_back(ok);
        end
    end
end

function automatic string to_text(input logic [127:0] v);
    string s;
    s = "";
    for (int i = 15; i >= 0; i--) begin
        if (v[8*i +: 8] != 8'h00) begin
            s = {s, $sformatf("%c", v[8*i +: 8])};
        end
    end
    return s;
endfunction

task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t got);
    if (got !== exp) begin
        $display("CHECK FAILED %s: expected byte 0x%02h, actual 0x%02h", name, exp, got);
        errors++;
    end
endtask

task automatic check_rx_word(input string name, input uart_rx_word_t exp,
                             input uart_rx_word_t got);
    if (got !== exp) begin
        $display("CHECK FAILED %s: expected RX word 0x%08h, actual 0x%08h", name, exp, got);
        errors++;
    end
endtask

task automatic check_cmd(input string name, input uart_cmd_e exp, input uart_cmd_e got);
    if (got !== exp) begin
        $display("CHECK FAILED %s: expected command word %0d, actual %0d", name, exp, got);
        errors++;
    end
endtask

task automatic load_tests();
    int               fd;
    int               n;
    logic [127:0]     tok;
    logic [127:0]     name;
    logic [8*256-1:0] rest;
    logic [31:0]      a0;
    logic [31:0]      a1;
    logic [31:0]      ex;
    uart_div_t        div;
    num_tests = 0;
    budget_ns = 40000;
    div       = 16'd16;
    fd = $fopen("verif/uart_mailbox_tests.txt", "r");
    if (fd == 0) begin
        $display("Could not open the test file verif/uart_mailbox_tests.txt");
    end else begin
        while ($fscanf(fd, "%s", tok) == 1 && num_tests < MAX_TESTS) begin
            if (tok == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%s %h %h %h", name, a0, a1, ex);
                if (n != 4) begin
                    $display("Test line for %s is malformed", to_text(tok));
                    errors++;
                end
                test_op[num_tests]   = tok;
                test_name[num_tests] = to_text(name);
                test_arg0[num_tests] = a0;
                test_arg1[num_tests] = a1;
                test_exp[num_tests]  = ex;
                if (tok == "div") begin
                    div = a0[15:0];
                end
                // Room for twelve frames of eleven bits at the divider in force.
                budget_ns += longint'(12 * 11 * CLK_PERIOD) * longint'(div);
                num_tests++;
            end
        end
        $fclose(fd);
    end
endtask

task automatic write_word(input int addr, input logic [31:0] value);
    @(negedge clk_i);
    mem[addr] = value;
endtask

// Writes a command and waits a bounded time for the controller to clear it.
task automatic run_cmd(input string name, input uart_cmd_e cmd, input int max_cycles,
                       input uart_cmd_e exp);
    int waited;
    waited = 0;
    write_word(`UART_CMD_ADDR, cmd);
    while (mem[`UART_CMD_ADDR] != NOP_CMD && waited < max_cycles) begin
        @(negedge clk_i);
        waited++;
    end
    check_cmd(name, exp, uart_cmd_e'(mem[`UART_CMD_ADDR]));
endtask

task automatic send_frame(input uart_byte_t data, input bit flip);
    logic [`UART_DATA_WIDTH+2:0] bits;
    int                          nbits;
    if (cur_ctrl.parity_en) begin
        bits  = {1'b1, ^data ^ cur_ctrl.parity_odd ^ flip, data, 1'b0};
        nbits = `UART_DATA_WIDTH + 3;
    end else begin
        bits  = {2'b11, data, 1'b0};
        nbits = `UART_DATA_WIDTH + 2;
    end
    for (int i = 0; i < nbits; i++) begin
        @(negedge clk_i);
        uart_rx_i = bits[i];
        repeat (cur_div - 1) @(negedge clk_i);
    end
    // Idle gap so the receiver has pushed the beat.
    repeat (cur_div) @(negedge clk_i);
endtask

task automatic wait_frames(input string name, input int count, input int max_cycles);
    int waited;
    waited = 0;
    while (tx_frames.size() < count && waited < max_cycles) begin
        @(negedge clk_i);
        waited++;
    end
    if (tx_frames.size() < count) begin
        $display("Test %s: only %0d of %0d frames came out on uart_tx_o",
                 name, tx_frames.size(), count);
        errors++;
    end
endtask

task automatic check_frame(input string name, input uart_byte_t exp);
    uart_byte_t got;
    bit         ok;
    if (tx_frames.size() > 0) begin
        got = tx_frames.pop_front();
        ok  = tx_frame_ok.pop_front();
        check_byte(name, exp, got);
        if (!ok) begin
            $display("Test %s: frame 0x%02h carried a wrong parity bit", name, got);
            errors++;
        end
    end
endtask

task automatic run_test(input int t);
    string       name;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] ex;
    uart_ctrl_t  flush_ctrl;
    int          limit;
    name  = test_name[t];
    a0    = test_arg0[t];
    a1    = test_arg1[t];
    ex    = test_exp[t];
    limit = 12 * 11 * int'(cur_div) + 64;
    case (test_op[t])
        "div": begin
            write_word(`UART_DIV_ADDR, a0);
            run_cmd(name, DIVIDER_CMD, 16, uart_cmd_e'(ex));
            cur_div = a0[15:0];
        end
        "ctrl": begin
            write_word(`UART_CTRL_ADDR, a0);
            run_cmd(name, CONTROL_CMD, 16, uart_cmd_e'(ex));
            cur_ctrl = uart_ctrl_t'(a0);
        end
        "tx": begin
            tx_frames.delete();
            tx_frame_ok.delete();
            write_word(`UART_TX_ADDR, a0);
            run_cmd(name, TX_DATA_CMD, limit, NOP_CMD);
            wait_frames(name, 1, limit);
            check_frame(name, ex[7:0]);
        end
        "burst": begin
            tx_frames.delete();
            tx_frame_ok.delete();
            for (int i = 0; i < int'(a0); i++) begin
                write_word(`UART_TX_ADDR, a1 + i);
                run_cmd(name, TX_DATA_CMD, limit, NOP_CMD);
            end
            wait_frames(name, int'(a0), limit * int'(a0));
            for (int i = 0; i < int'(a0); i++) begin
                check_frame(name, uart_byte_t'(ex[7:0] + i));
            end
        end
        "rx": begin
            send_frame(a0[7:0], a1[0]);
            run_cmd(name, RX_DATA_CMD, limit, NOP_CMD);
            check_rx_word(name, uart_rx_word_t'(ex), uart_rx_word_t'(mem[`UART_RX_ADDR]));
        end
        "flush": begin
            send_frame(a0[7:0], 1'b0);
            flush_ctrl          = cur_ctrl;
            flush_ctrl.rx_flush = 1'b1;
            write_word(`UART_CTRL_ADDR, flush_ctrl);
            run_cmd(name, CONTROL_CMD, 16, NOP_CMD);
            write_word(`UART_CTRL_ADDR, cur_ctrl);
            run_cmd(name, CONTROL_CMD, 16, NOP_CMD);
            send_frame(a1[7:0], 1'b0);
            run_cmd(name, RX_DATA_CMD, limit, NOP_CMD);
            check_rx_word(name, uart_rx_word_t'(ex), uart_rx_word_t'(mem[`UART_RX_ADDR]));
        end
        default: begin
            $display("Test %s has an unknown operation %s", name, to_text(test_op[t]));
            errors++;
        end
    endcase
endtask

initial begin : main
    int errors_before;
    int failed_tests;
    arstn_i      = 1'b0;
    uart_rx_i    = 1'b1;
    mem_rdata_i  = '0;
    errors       = 0;
    failed_tests = 0;
    budget_ready = 1'b0;
    cur_div      = 16'd16;
    cur_ctrl     = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = '0;
    end
    load_tests();
    budget_ready = 1'b1;
    repeat (4) @(negedge clk_i);
    arstn_i = 1'b1;
    repeat (2) @(negedge clk_i);
    if (num_tests == 0) begin
        $display("No tests were read, nothing was run");
        errors++;
    end
    for (int t = 0; t < num_tests; t++) begin
        errors_before = errors;
        run_test(t);
        if (errors == errors_before) begin
            $display("test %s: passed", test_name[t]);
        end else begin
            $display("test %s: failed", test_name[t]);
            failed_tests++;
        end
    end
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", num_tests, failed_tests,
             errors);
    if (errors == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

initial begin : watchdog
    wait (budget_ready);
    #(budget_ns);
    $display("Watchdog expired after %0d ns, the run hung and was stopped", budget_ns);
    $display("FAIL: see errors above");
    $finish;
end

endmodule

`default_nettype wire

//--- design/uart_mailbox_top.sv
// Top level of the RAM-mailbox UART: controller, TX and RX FIFOs and both engines.
// The RAM sits outside; its port is brought straight out.

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module uart_mailbox_top (
    input  logic                        clk_i,
    input  logic                        arstn_i,

    input  logic                        uart_rx_i,
    output logic                        uart_tx_o,

    input  logic [`UART_MEM_WIDTH-1:0]  mem_rdata_i,
    output logic [`UART_MEM_WIDTH-1:0]  mem_wdata_o,
    output logic [`UART_ADDR_WIDTH-1:0] mem_addr_o,
    output logic [`UART_BYTE_NUM-1:0]   mem_wr_en_o
);

import uart_reg_pkg::*;
import uart_stream_pkg::*;

uart_div_t     div;
uart_ctrl_t    ctrl;

uart_byte_t    tx_push_beat;
logic          tx_push_valid;
logic          tx_push_ready;
uart_byte_t    tx_line_beat;
logic          tx_line_valid;
logic          tx_line_ready;

uart_rx_beat_t rx_line_beat;
logic          rx_line_valid;
logic          rx_line_ready;
uart_rx_beat_t rx_pop_beat;
logic          rx_pop_valid;
logic          rx_pop_ready;

uart_bram_ctrl uart_bram_ctrl_inst (
    .clk_i       (clk_i        ),
    .arstn_i     (arstn_i      ),
    .mem_rdata_i (mem_rdata_i  ),
    .mem_wdata_o (mem_wdata_o  ),
    .mem_addr_o  (mem_addr_o   ),
    .mem_wr_en_o (mem_wr_en_o  ),
    .tx_beat_o   (tx_push_beat ),
    .tx_valid_o  (tx_push_valid),
    .tx_ready_i  (tx_push_ready),
    .rx_beat_i   (rx_pop_beat  ),
    .rx_valid_i  (rx_pop_valid ),
    .rx_ready_o  (rx_pop_ready ),
    .div_o       (div          ),
    .ctrl_o      (ctrl         )
);

stream_fifo #(
    .payload_t (uart_byte_t)
) tx_fifo_inst (
    .clk_i     (clk_i        ),
    .arstn_i   (arstn_i      ),
    .clr_i     (ctrl.tx_flush),
    .s_data_i  (tx_push_beat ),
    .s_valid_i (tx_push_valid),
    .s_ready_o (tx_push_ready),
    .m_data_o  (tx_line_beat ),
    .m_valid_o (tx_line_valid),
    .m_ready_i (tx_line_ready)
);

uart_tx uart_tx_inst (
    .clk_i     (clk_i        ),
    .arstn_i   (arstn_i      ),
    .clr_i     (ctrl.tx_flush),
    .div_i     (div          ),
    .ctrl_i    (ctrl         ),
    .data_i    (tx_line_beat ),
    .valid_i   (tx_line_valid),
    .ready_o   (tx_line_ready),
    .uart_tx_o (uart_tx_o    )
);

uart_rx uart_rx_inst (
    .clk_i     (clk_i        ),
    .arstn_i   (arstn_i      ),
    .clr_i     (ctrl.rx_flush),
    .div_i     (div          ),
    .ctrl_i    (ctrl         ),
    .uart_rx_i (uart_rx_i    ),
    .beat_o    (rx_line_beat ),
    .valid_o   (rx_line_valid),
    .ready_i   (rx_line_ready)
);

stream_fifo #(
    .payload_t (uart_rx_beat_t)
) rx_fifo_inst (
    .clk_i     (clk_i        ),
    .arstn_i   (arstn_i      ),
    .clr_i     (ctrl.rx_flush),
    .s_data_i  (rx_line_beat ),
    .s_valid_i (rx_line_valid),
    .s_ready_o (rx_line_ready),
    .m_data_o  (rx_pop_beat  ),
    .m_valid_o (rx_pop_valid ),
    .m_ready_i (rx_pop_ready )
);

endmodule

`default_nettype wire

//--- design/uart_bram_ctrl.sv
// Polls the command word in the shared RAM and runs one command at a time.
// Holds the divider and control registers; writes zero to the command word when done.

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module uart_bram_ctrl (
    input  logic                           clk_i,
    input  logic                           arstn_i,

    input  logic [`UART_MEM_WIDTH-1:0]     mem_rdata_i,
    output logic [`UART_MEM_WIDTH-1:0]     mem_wdata_o,
    output logic [`UART_ADDR_WIDTH-1:0]    mem_addr_o,
    output logic [`UART_BYTE_NUM-1:0]      mem_wr_en_o,

    output uart_stream_pkg::uart_byte_t    tx_beat_o,
    output logic                           tx_valid_o,
    input  logic                           tx_ready_i,

    input  uart_stream_pkg::uart_rx_beat_t rx_beat_i,
    input  logic                           rx_valid_i,
    output logic                           rx_ready_o,

    output uart_reg_pkg::uart_div_t        div_o,
    output uart_reg_pkg::uart_ctrl_t       ctrl_o
);

import uart_reg_pkg::*;

localparam int AW     = `UART_ADDR_WIDTH;
localparam int STEP_W = $clog2(`UART_POLL_DELAY);

localparam logic [AW-1:0] CMD_ADDR  = AW'(`UART_CMD_ADDR);
localparam logic [AW-1:0] DIV_ADDR  = AW'(`UART_DIV_ADDR);
localparam logic [AW-1:0] CTRL_ADDR = AW'(`UART_CTRL_ADDR);
localparam logic [AW-1:0] TX_ADDR   = AW'(`UART_TX_ADDR);
localparam logic [AW-1:0] RX_ADDR   = AW'(`UART_RX_ADDR);

localparam logic [STEP_W-1:0] STEP_ADDR  = '0;
localparam logic [STEP_W-1:0] STEP_WRITE = STEP_W'(1);
localparam logic [STEP_W-1:0] STEP_DATA  = STEP_W'(2);
localparam logic [STEP_W-1:0] STEP_ACK   = STEP_W'(`UART_POLL_DELAY - 1);

typedef enum logic [2:0] {
    IDLE,
    DIVIDER,
    CONTROL,
    TX_DATA,
    RX_DATA
} state_e;

state_e            state;
logic [STEP_W-1:0] step;
logic              tx_load;
uart_rx_word_t     rx_word;

assign rx_ready_o = (state == RX_DATA) && (step == STEP_ADDR);
assign tx_load    = (state == TX_DATA) && (step == STEP_DATA) && ~tx_valid_o;

assign rx_word.reserved   = '0;
assign rx_word.parity_err = rx_beat_i.parity_err;
assign rx_word.data       = rx_beat_i.data;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        state       <= IDLE;
        step        <= '0;
        mem_addr_o  <= CMD_ADDR;
        mem_wdata_o <= '0;
        mem_wr_en_o <= '0;
        tx_valid_o  <= 1'b0;
        div_o       <= DIV_RESET;
        ctrl_o      <= '0;
    end else begin
        step        <= step + 1'b1;
        mem_wr_en_o <= '0;
        case (state)
            IDLE: begin
                mem_addr_o <= CMD_ADDR;
                // After an acknowledge the read back needs two cycles to show NOP.
                if (step == STEP_DATA) begin
                    step <= STEP_DATA;
                    case (uart_cmd_e'(mem_rdata_i))
                        DIVIDER_CMD: state <= DIVIDER;
                        CONTROL_CMD: state <= CONTROL;
                        TX_DATA_CMD: state <= TX_DATA;
                        RX_DATA_CMD: state <= RX_DATA;
                        default:     ;
                    endcase
                    if (uart_cmd_e'(mem_rdata_i) inside {DIVIDER_CMD, CONTROL_CMD,
                                                         TX_DATA_CMD, RX_DATA_CMD}) begin
                        step <= STEP_ADDR;
                    end
                end
            end
            DIVIDER: begin
                if (step == STEP_ADDR) begin
                    mem_addr_o <= DIV_ADDR;
                end
                if (step == STEP_DATA) begin
                    div_o <= mem_rdata_i[$bits(uart_div_t)-1:0];
                end
            end
            CONTROL: begin
                if (step == STEP_ADDR) begin
                    mem_addr_o <= CTRL_ADDR;
                end
                if (step == STEP_DATA) begin
                    ctrl_o <= uart_ctrl_t'(mem_rdata_i);
                end
            end
            TX_DATA: begin
                if (step == STEP_ADDR) begin
                    mem_addr_o <= TX_ADDR;
                end
                // Stay here until the TX FIFO takes the byte.
                if (step == STEP_DATA) begin
                    if (tx_valid_o && tx_ready_i) begin
                        tx_valid_o <= 1'b0;
                    end else begin
                        tx_valid_o <= 1'b1;
                        step       <= step;
                    end
                end
            end
            RX_DATA: begin
                if (step == STEP_ADDR) begin
                    if (rx_valid_i) begin
                        mem_wdata_o <= rx_word;
                    end else begin
                        step <= step;
                    end
                end
                if (step == STEP_WRITE) begin
                    mem_addr_o  <= RX_ADDR;
                    mem_wr_en_o <= '1;
                end
            end
            default: state <= IDLE;
        endcase

        // Acknowledge, shared by every command.
        if (state != IDLE && step == STEP_ACK) begin
            mem_addr_o  <= CMD_ADDR;
            mem_wdata_o <= NOP_CMD;
            mem_wr_en_o <= '1;
            state       <= IDLE;
            step        <= '0;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (tx_load) begin
        tx_beat_o <= mem_rdata_i[`UART_DATA_WIDTH-1:0];
    end
end

// A pending TX beat keeps its byte until the FIFO accepts it.
a_tx_hold: assert property (@(posedge clk_i) disable iff (~arstn_i)
    (tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_beat_o)));

// RAM writes are whole words, to the command or the RX word only.
a_wr_en_word: assert property (@(posedge clk_i) disable iff (~arstn_i)
    (mem_wr_en_o != '0) |->
        ((mem_wr_en_o == '1) && (mem_addr_o == CMD_ADDR || mem_addr_o == RX_ADDR)));

endmodule

`default_nettype wire

//--- design/uart_rx.sv
// Serial receiver: two-flop line synchronizer, start detection and mid-bit sampling.
// Pushes one beat per frame with the parity check result in parity_err.

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module uart_rx (
    input  logic                           clk_i,
    input  logic                           arstn_i,
    input  logic                           clr_i,

    input  uart_reg_pkg::uart_div_t        div_i,
    input  uart_reg_pkg::uart_ctrl_t       ctrl_i,

    input  logic                           uart_rx_i,

    output uart_stream_pkg::uart_rx_beat_t beat_o,
    output logic                           valid_o,
    input  logic                           ready_i
);

import uart_reg_pkg::*;

localparam int IDX_W = $clog2(`UART_DATA_WIDTH);

typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
} rx_state_e;

rx_state_e                   state;
logic [1:0]                  sync_q;
logic                        line;
logic                        tick;
uart_div_t                   baud_cnt;
logic [IDX_W-1:0]            bit_idx;
logic [`UART_DATA_WIDTH-1:0] data_q;
logic                        parity_err_q;

assign line              = sync_q[1];
assign tick              = (baud_cnt == '0);
assign beat_o.data       = data_q;
assign beat_o.parity_err = parity_err_q;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        sync_q <= '1;
    end else begin
        sync_q <= {sync_q[0], uart_rx_i};
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        state    <= RX_IDLE;
        baud_cnt <= '0;
        bit_idx  <= '0;
        valid_o  <= 1'b0;
    end else if (clr_i) begin
        state   <= RX_IDLE;
        valid_o <= 1'b0;
    end else begin
        baud_cnt <= baud_cnt - 1'b1;
        if (ready_i) begin
            valid_o <= 1'b0;
        end
        case (state)
            RX_IDLE: begin
                // Half a bit first, so every later sample falls mid-bit.
                if (~line) begin
                    state    <= RX_START;
                    baud_cnt <= (div_i >> 1) - 1'b1;
                end
            end
            RX_START: begin
                if (tick) begin
                    if (~line) begin
                        // A beat the FIFO never took is lost here.
                        state    <= RX_DATA;
                        baud_cnt <= div_i - 1'b1;
                        bit_idx  <= '0;
                        valid_o  <= 1'b0;
                    end else begin
                        state <= RX_IDLE;
                    end
                end
            end
            RX_DATA: begin
                if (tick) begin
                    baud_cnt <= div_i - 1'b1;
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == '1) begin
                        state <= ctrl_i.parity_en ? RX_PARITY : RX_STOP;
                    end
                end
            end
            RX_PARITY: begin
                if (tick) begin
                    baud_cnt <= div_i - 1'b1;
                    state    <= RX_STOP;
                end
            end
            RX_STOP: begin
                if (tick) begin
                    state   <= RX_IDLE;
                    valid_o <= 1'b1;
                end
            end
            default: state <= RX_IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (state == RX_START && tick) begin
        parity_err_q <= 1'b0;
    end
    if (state == RX_DATA && tick) begin
        data_q <= {line, data_q[`UART_DATA_WIDTH-1:1]};
    end
    if (state == RX_PARITY && tick) begin
        parity_err_q <= line ^ (^data_q) ^ ctrl_i.parity_odd;
    end
end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
// Serial transmitter: start bit, 8 data bits LSB first, optional parity, one stop bit.
// Each bit lasts div_i cycles; ready_o is high only between frames.

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module uart_tx (
    input  logic                        clk_i,
    input  logic                        arstn_i,
    input  logic                        clr_i,

    input  uart_reg_pkg::uart_div_t     div_i,
    input  uart_reg_pkg::uart_ctrl_t    ctrl_i,

    input  uart_stream_pkg::uart_byte_t data_i,
    input  logic                        valid_i,
    output logic                        ready_o,

    output logic                        uart_tx_o
);

import uart_reg_pkg::*;

localparam int FRAME_W = `UART_DATA_WIDTH + 3;
localparam int CNT_W   = $clog2(FRAME_W + 1);

logic [FRAME_W-1:0] shift_q;
logic [CNT_W-1:0]   bits_left;
uart_div_t          baud_cnt;
logic               busy;
logic               parity_bit;

// Even parity is the XOR of the data bits.
assign parity_bit = (^data_i) ^ ctrl_i.parity_odd;
assign ready_o    = ~busy;
assign uart_tx_o  = shift_q[0];

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        shift_q   <= '1;
        bits_left <= '0;
        baud_cnt  <= '0;
        busy      <= 1'b0;
    end else if (clr_i) begin
        shift_q   <= '1;
        bits_left <= '0;
        busy      <= 1'b0;
    end else if (~busy) begin
        if (valid_i) begin
            // Without parity the top two bits are both stop level.
            shift_q   <= {1'b1, ctrl_i.parity_en ? parity_bit : 1'b1, data_i, 1'b0};
            bits_left <= ctrl_i.parity_en ? CNT_W'(FRAME_W) : CNT_W'(FRAME_W - 1);
            baud_cnt  <= div_i - 1'b1;
            busy      <= 1'b1;
        end
    end else if (baud_cnt == '0) begin
        shift_q   <= {1'b1, shift_q[FRAME_W-1:1]};
        bits_left <= bits_left - 1'b1;
        baud_cnt  <= div_i - 1'b1;
        if (bits_left == CNT_W'(1)) begin
            busy <= 1'b0;
        end
    end else begin
        baud_cnt <= baud_cnt - 1'b1;
    end
end

endmodule

`default_nettype wire

//--- design/stream_fifo.sv
// Synchronous valid/ready FIFO for one stream; the payload type is a parameter.
// A pushed beat shows at the output on the next cycle, and clr_i empties it.

`timescale 1ns/1ns
`default_nettype none

`include "uart_params.svh"

module stream_fifo #(
    parameter type payload_t = logic [`UART_DATA_WIDTH-1:0],
    parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
    input  logic     clk_i,
    input  logic     arstn_i,
    input  logic     clr_i,

    input  payload_t s_data_i,
    input  logic     s_valid_i,
    output logic     s_ready_o,

    output payload_t m_data_o,
    output logic     m_valid_o,
    input  logic     m_ready_i
);

localparam int          AW   = $clog2(DEPTH);
localparam logic [AW:0] FULL = (AW + 1)'(DEPTH);

payload_t      mem [DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [AW:0]   count;
logic          push;
logic          pop;

assign s_ready_o = (count != FULL);
assign m_valid_o = (count != '0);
assign m_data_o  = mem[rd_ptr];
assign push      = s_valid_i & s_ready_o;
assign pop       = m_valid_o & m_ready_i;

always_ff @(posedge clk_i) begin
    if (push) begin
        mem[wr_ptr] <= s_data_i;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else if (clr_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
        endcase
    end
end

// Occupancy never runs past full, and a full FIFO has its pointers level.
a_no_push_full: assert property (@(posedge clk_i) disable iff (~arstn_i)
    (count <= FULL) && ((count == FULL) -> (wr_ptr == rd_ptr)));
// An empty FIFO has nothing between its pointers.
a_no_pop_empty: assert property (@(posedge clk_i) disable iff (~arstn_i)
    (count == '0) |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

//--- design/uart_stream_pkg.sv
// Payload types of the byte streams between the UART engines and the FIFOs.

`default_nettype none

`include "uart_params.svh"

package uart_stream_pkg;

typedef logic [`UART_DATA_WIDTH-1:0] uart_byte_t;

// One received frame.
typedef struct packed {
    logic       parity_err;
    uart_byte_t data;
} uart_rx_beat_t;

endpackage

`default_nettype wire

//--- design/uart_reg_pkg.sv
// Command codes and the layout of the RAM words the host shares with the UART.
// Used by the controller, the UART engines and the testbench.

`default_nettype none

`include "uart_params.svh"

package uart_reg_pkg;

typedef enum logic [`UART_MEM_WIDTH-1:0] {
    NOP_CMD     = 0,
    DIVIDER_CMD = 1,
    CONTROL_CMD = 2,
    TX_DATA_CMD = 3,
    RX_DATA_CMD = 4
} uart_cmd_e;

// Bit 0 is parity_en.
typedef struct packed {
    logic [`UART_MEM_WIDTH-5:0] reserved;
    logic                       rx_flush;
    logic                       tx_flush;
    logic                       parity_odd;
    logic                       parity_en;
} uart_ctrl_t;

// Clock cycles per serial bit, low half of the divider word.
typedef logic [15:0] uart_div_t;

localparam uart_div_t DIV_RESET = 16'd16;

typedef struct packed {
    logic [`UART_MEM_WIDTH-`UART_DATA_WIDTH-2:0] reserved;
    logic                                        parity_err;
    logic [`UART_DATA_WIDTH-1:0]                 data;
} uart_rx_word_t;

endpackage

`default_nettype wire

//--- include/uart_params.svh
// Widths, FIFO depth, RAM word map and command step count of the UART mailbox.
// Included by every package and module that sizes a port or a register.

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Serial byte and RAM word geometry.
`define UART_DATA_WIDTH 8
`define UART_MEM_WIDTH  32
`define UART_BYTE_NUM   4
`define UART_ADDR_WIDTH 8

// Entries in each stream FIFO, a power of two.
`define UART_FIFO_DEPTH 16

// Word addresses in the shared RAM.
`define UART_CMD_ADDR  0
`define UART_DIV_ADDR  1
`define UART_CTRL_ADDR 2
`define UART_TX_ADDR   3
`define UART_RX_ADDR   4

// Steps of one command sequence.
`define UART_POLL_DELAY 4

`endif
